// File: ant_tick.f
verilog/ant_pkg.sv
verilog/dp_issuer.sv
verilog/ant_update.sv
verilog/ant_draw.sv
verilog/ant_tick.sv
tests/ant_tick_props.sv
tests/ant_tick_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module ant_tick_tb \
    -f ant_tick.f \
    -o ant_tick_sim

output=$(./obj_dir/ant_tick_sim 2>&1) || true
echo "$output"

if echo "$output" | grep -q "All checks passed"; then
    exit 0
fi
exit 1

// File: tests/ant_tick_props.sv
`timescale 1ns/10ps

module ant_tick_props (
    input logic               clock,
    input logic               resetn,
    input logic               finished,
    input logic               start_dp,
    input ant_pkg::dp_instr_t instr_dp
);

    // Strobe length checked on its falling edge
    strobe_length: assert property (
        @(posedge clock) disable iff (!resetn)
        $fell(start_dp) |-> $past(start_dp, 2) && !$past(start_dp, 3)
    ) else $error("start_dp strobe did not last exactly two cycles");

    instr_stable: assert property (
        @(posedge clock) disable iff (!resetn)
        start_dp && $past(start_dp) |-> $stable(instr_dp)
    ) else $error("instr_dp changed while start_dp was high");

    // No datapath traffic outside a tick
    strobe_while_busy: assert property (
        @(posedge clock) disable iff (!resetn)
        $rose(start_dp) |-> !finished
    ) else $error("start_dp rose while finished was high");

endmodule

bind ant_tick ant_tick_props u_props (
    .clock    (clock),
    .resetn   (resetn),
    .finished (finished),
    .start_dp (start_dp),
    .instr_dp (instr_dp)
);

// File: tests/ant_tick_tb.sv
`timescale 1ns/10ps

module ant_tick_tb;

    localparam int num_steps      = 200;
    localparam int cmds_per_step  = 24;
    localparam int cycles_per_cmd = 10;
    localparam int clock_period   = 20;

    // Clamp limits for the ant centre derived from the screen and sprite sizes
    localparam ant_pkg::x_coord_t x_lo = ant_pkg::x_coord_t'(ant_pkg::ant_width / 2);
    localparam ant_pkg::x_coord_t x_hi =
        ant_pkg::x_coord_t'(ant_pkg::screen_width - ant_pkg::ant_width / 2 - 1);
    localparam ant_pkg::y_coord_t y_lo = ant_pkg::y_coord_t'(ant_pkg::ant_height / 2);
    localparam ant_pkg::y_coord_t y_hi =
        ant_pkg::y_coord_t'(ant_pkg::screen_height - ant_pkg::ant_height / 2 - 1);

    logic               clock;
    logic               resetn;
    logic               start;
    ant_pkg::ant_id_t   id;
    ant_pkg::move_t     move;
    logic               finished_dp;
    ant_pkg::result_t   result_dp;
    logic               finished;
    logic               start_dp;
    ant_pkg::dp_instr_t instr_dp;

    logic [31:0]        seed = 32'h902d5631;
    ant_pkg::result_t   mem [64];
    ant_pkg::dp_instr_t expected [$];
    int                 delays [$];
    ant_pkg::x_coord_t  exp_x;
    ant_pkg::y_coord_t  exp_y;
    ant_pkg::fitness_t  exp_fit;

    ant_tick u_dut (
        .clock       (clock),
        .resetn      (resetn),
        .start       (start),
        .id          (id),
        .move        (move),
        .finished_dp (finished_dp),
        .result_dp   (result_dp),
        .finished    (finished),
        .start_dp    (start_dp),
        .instr_dp    (instr_dp)
    );

    initial begin
        clock = 1'b0;
        forever #(clock_period / 2) clock = ~clock;
    end

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic int word_index(ant_pkg::ant_id_t ant_id, ant_pkg::ant_field_t field);
        ant_pkg::ant_addr_t addr;
        addr.id    = ant_id;
        addr.field = field;
        return int'(addr);
    endfunction

    function automatic ant_pkg::dp_instr_t make_instr(ant_pkg::dp_op_t op,
            ant_pkg::ant_id_t ant_id, ant_pkg::ant_field_t field, ant_pkg::result_t wdata,
            ant_pkg::x_coord_t px, ant_pkg::y_coord_t py, ant_pkg::colour_t colour);
        ant_pkg::dp_instr_t instr;
        instr            = '0;
        instr.op         = op;
        instr.addr.id    = ant_id;
        instr.addr.field = field;
        instr.wdata      = wdata;
        instr.px         = px;
        instr.py         = py;
        instr.colour     = colour;
        return instr;
    endfunction

    task automatic report_failure(string text);
        $display("%s", text);
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic check_instr(ant_pkg::dp_instr_t got, ant_pkg::dp_instr_t exp, string what);
        if (got !== exp) begin
            report_failure($sformatf("mismatch at %0t: %s got %h expected %h",
                $time, what, got, exp));
        end
    endtask

    task automatic check_coord_x(ant_pkg::x_coord_t got, ant_pkg::x_coord_t exp, string what);
        if (got !== exp) begin
            report_failure($sformatf("mismatch at %0t: %s got %0d expected %0d",
                $time, what, got, exp));
        end
    endtask

    task automatic check_coord_y(ant_pkg::y_coord_t got, ant_pkg::y_coord_t exp, string what);
        if (got !== exp) begin
            report_failure($sformatf("mismatch at %0t: %s got %0d expected %0d",
                $time, what, got, exp));
        end
    endtask

    task automatic check_fitness(ant_pkg::fitness_t got, ant_pkg::fitness_t exp, string what);
        if (got !== exp) begin
            report_failure($sformatf("mismatch at %0t: %s got %0d expected %0d",
                $time, what, got, exp));
        end
    endtask

    task automatic check_flag(logic got, logic exp, string what);
        if (got !== exp) begin
            report_failure($sformatf("mismatch at %0t: %s got %b expected %b",
                $time, what, got, exp));
        end
    endtask

    function automatic void preload_memory();
        for (int a = 0; a < 64; a++) begin
            mem[a] = ant_pkg::result_t'(a) ^ 16'ha5c3;
        end
        for (int i = 0; i < 16; i++) begin
            mem[word_index(ant_pkg::ant_id_t'(i), ant_pkg::field_x)] =
                ant_pkg::result_t'(32'd4 + (next_rand() >> 16) % 32'd152);
            mem[word_index(ant_pkg::ant_id_t'(i), ant_pkg::field_y)] =
                ant_pkg::result_t'(32'd4 + (next_rand() >> 16) % 32'd112);
            mem[word_index(ant_pkg::ant_id_t'(i), ant_pkg::field_fitness)] =
                ant_pkg::result_t'(next_rand() >> 24);
        end
        // A few ants start on or next to the clamp limits
        mem[word_index(4'd0, ant_pkg::field_x)] = ant_pkg::result_t'(x_lo);
        mem[word_index(4'd0, ant_pkg::field_y)] = ant_pkg::result_t'(y_lo);
        mem[word_index(4'd1, ant_pkg::field_x)] = ant_pkg::result_t'(x_hi);
        mem[word_index(4'd1, ant_pkg::field_y)] = ant_pkg::result_t'(y_hi);
        mem[word_index(4'd2, ant_pkg::field_x)] = ant_pkg::result_t'(x_hi - 8'd1);
        mem[word_index(4'd2, ant_pkg::field_y)] = ant_pkg::result_t'(y_lo + 7'd1);
        mem[word_index(4'd3, ant_pkg::field_x)] = ant_pkg::result_t'(x_lo + 8'd1);
        mem[word_index(4'd3, ant_pkg::field_y)] = ant_pkg::result_t'(y_hi - 7'd1);
    endfunction

    // Reference command list and response delays for one step
    task automatic build_expected(ant_pkg::ant_id_t step_id, ant_pkg::move_t step_move);
        ant_pkg::x_coord_t x;
        ant_pkg::y_coord_t y;
        x       = ant_pkg::x_coord_t'(mem[word_index(step_id, ant_pkg::field_x)]);
        y       = ant_pkg::y_coord_t'(mem[word_index(step_id, ant_pkg::field_y)]);
        exp_fit = ant_pkg::fitness_t'(mem[word_index(step_id, ant_pkg::field_fitness)]);
        exp_x   = x;
        exp_y   = y;
        if (step_move.left && x > x_lo) begin
            exp_x = x - 8'd1;
        end else if (step_move.right && x < x_hi) begin
            exp_x = x + 8'd1;
        end
        if (step_move.up && y > y_lo) begin
            exp_y = y - 7'd1;
        end else if (step_move.down && y < y_hi) begin
            exp_y = y + 7'd1;
        end
        expected.push_back(make_instr(ant_pkg::op_memread, step_id, ant_pkg::field_x,
            '0, '0, '0, '0));
        expected.push_back(make_instr(ant_pkg::op_memread, step_id, ant_pkg::field_y,
            '0, '0, '0, '0));
        expected.push_back(make_instr(ant_pkg::op_memread, step_id, ant_pkg::field_fitness,
            '0, '0, '0, '0));
        expected.push_back(make_instr(ant_pkg::op_memwrite, step_id, ant_pkg::field_x,
            ant_pkg::result_t'(exp_x), '0, '0, '0));
        expected.push_back(make_instr(ant_pkg::op_memwrite, step_id, ant_pkg::field_y,
            ant_pkg::result_t'(exp_y), '0, '0, '0));
        expected.push_back(make_instr(ant_pkg::op_memwrite, step_id, ant_pkg::field_fitness,
            ant_pkg::result_t'(exp_fit), '0, '0, '0));
        expected.push_back(make_instr(ant_pkg::op_memread, step_id, ant_pkg::field_x,
            '0, '0, '0, '0));
        expected.push_back(make_instr(ant_pkg::op_memread, step_id, ant_pkg::field_y,
            '0, '0, '0, '0));
        for (int dy = 0; dy < ant_pkg::ant_height; dy++) begin
            for (int dx = 0; dx < ant_pkg::ant_width; dx++) begin
                expected.push_back(make_instr(ant_pkg::op_draw, '0, ant_pkg::field_x, '0,
                    exp_x - 8'd1 + ant_pkg::x_coord_t'(dx),
                    exp_y - 7'd1 + ant_pkg::y_coord_t'(dy), ant_pkg::colour_ant));
            end
        end
        for (int i = 0; i < cmds_per_step; i++) begin
            delays.push_back(1 + int'(next_rand() >> 28) % 4);
        end
    endtask

    task automatic run_step(ant_pkg::ant_id_t step_id, ant_pkg::move_t step_move,
            logic extra_start);
        logic [31:0] r;
        build_expected(step_id, step_move);
        @(posedge clock);
        #2;
        start = 1'b1;
        id    = step_id;
        move  = step_move;
        @(posedge clock);
        #2;
        start = 1'b0;
        // Busy start with different arguments that must be ignored
        if (extra_start) begin
            r = next_rand();
            repeat (2 + int'(r[2:0])) @(posedge clock);
            #2;
            start = 1'b1;
            id    = ~step_id;
            move  = ~step_move;
            @(posedge clock);
            #2;
            start = 1'b0;
        end
        @(negedge clock);
        while (!finished) begin
            @(negedge clock);
        end
        if (expected.size() != 0) begin
            report_failure($sformatf("Step for ant %0d ended with %0d commands never issued",
                step_id, expected.size()));
        end
        repeat (2) @(posedge clock);
    endtask

    // Datapath and memory model
    initial begin : datapath_model
        ant_pkg::dp_instr_t cmd;
        ant_pkg::result_t   rdata;
        int                 delay;
        forever begin
            @(negedge clock);
            if (start_dp) begin
                cmd = instr_dp;
                while (start_dp) begin
                    @(negedge clock);
                end
                if (expected.size() == 0) begin
                    report_failure("A datapath command was issued when none was expected");
                end
                // Written words against the stepped ant record
                if (cmd.op == ant_pkg::op_memwrite) begin
                    case (cmd.addr.field)
                        ant_pkg::field_x: begin
                            check_coord_x(ant_pkg::x_coord_t'(cmd.wdata), exp_x,
                                "written x");
                        end
                        ant_pkg::field_y: begin
                            check_coord_y(ant_pkg::y_coord_t'(cmd.wdata), exp_y,
                                "written y");
                        end
                        ant_pkg::field_fitness: begin
                            check_fitness(ant_pkg::fitness_t'(cmd.wdata), exp_fit,
                                "written fitness");
                        end
                        default: ;
                    endcase
                end
                check_instr(cmd, expected.pop_front(), "datapath command");
                rdata = '0;
                case (cmd.op)
                    ant_pkg::op_memread:  rdata = mem[int'(cmd.addr)];
                    ant_pkg::op_memwrite: mem[int'(cmd.addr)] = cmd.wdata;
                    default: ;
                endcase
                delay = (delays.size() > 0) ? delays.pop_front() : 1;
                repeat (delay) @(posedge clock);
                #2;
                finished_dp = 1'b1;
                result_dp   = rdata;
                @(posedge clock);
                #2;
                finished_dp = 1'b0;
                result_dp   = '0;
            end
        end
    end

    initial begin : watchdog
        #(num_steps * cmds_per_step * cycles_per_cmd * clock_period);
        report_failure("The simulation timed out before all steps finished");
    end

    initial begin : stimulus
        logic [31:0] r;
        resetn      = 1'b0;
        start       = 1'b0;
        id          = '0;
        move        = '0;
        finished_dp = 1'b0;
        result_dp   = '0;
        preload_memory();
        repeat (16) @(posedge clock);
        #2;
        resetn = 1'b1;
        @(negedge clock);
        check_flag(finished, 1'b1, "finished after reset");
        check_flag(start_dp, 1'b0, "start_dp after reset");
        check_instr(instr_dp, '0, "instr_dp after reset");
        for (int step = 0; step < num_steps; step++) begin
            r = next_rand();
            run_step(r[27:24], r[19:16], r[9:8] == 2'b00);
        end
        $display("All checks passed");
        $finish;
    end

endmodule

// File: verilog/ant_draw.sv
`timescale 1ns/10ps

module ant_draw (
    input  logic               clock,
    input  logic               resetn,
    input  logic               run,
    input  ant_pkg::ant_id_t   id,
    input  logic               done,
    input  ant_pkg::result_t   result,
    output logic               req,
    output ant_pkg::dp_instr_t req_instr,
    output logic               complete
);

    localparam logic [1:0] last_dx = 2'(ant_pkg::ant_width - 1);
    localparam logic [1:0] last_dy = 2'(ant_pkg::ant_height - 1);

    ant_pkg::draw_state_t state;

    // Top-left corner of the sprite
    ant_pkg::x_coord_t x;
    ant_pkg::y_coord_t y;
    logic [1:0]        dx;
    logic [1:0]        dy;

    always_ff @(posedge clock) begin
        if (!resetn) begin
            state    <= ant_pkg::drw_idle;
            req      <= 1'b0;
            complete <= 1'b0;
            dx       <= '0;
            dy       <= '0;
        end else begin
            req      <= 1'b0;
            complete <= 1'b0;
            case (state)
                ant_pkg::drw_idle: begin
                    if (run) begin
                        dx    <= '0;
                        dy    <= '0;
                        req   <= 1'b1;
                        state <= ant_pkg::drw_read_x;
                    end
                end
                ant_pkg::drw_read_x: begin
                    if (done) begin
                        x     <= ant_pkg::x_coord_t'(result) - 1'b1;
                        req   <= 1'b1;
                        state <= ant_pkg::drw_read_y;
                    end
                end
                ant_pkg::drw_read_y: begin
                    if (done) begin
                        y     <= ant_pkg::y_coord_t'(result) - 1'b1;
                        req   <= 1'b1;
                        state <= ant_pkg::drw_draw;
                    end
                end
                // Raster walk, dx inner
                ant_pkg::drw_draw: begin
                    if (done) begin
                        if (dx == last_dx) begin
                            dx <= '0;
                            if (dy == last_dy) begin
                                complete <= 1'b1;
                                state    <= ant_pkg::drw_idle;
                            end else begin
                                dy  <= dy + 1'b1;
                                req <= 1'b1;
                            end
                        end else begin
                            dx  <= dx + 1'b1;
                            req <= 1'b1;
                        end
                    end
                end
                default: begin
                    state <= ant_pkg::drw_idle;
                end
            endcase
        end
    end

    always_comb begin
        req_instr = '0;
        case (state)
            ant_pkg::drw_draw: begin
                req_instr.op     = ant_pkg::op_draw;
                req_instr.px     = x + ant_pkg::x_coord_t'(dx);
                req_instr.py     = y + ant_pkg::y_coord_t'(dy);
                req_instr.colour = ant_pkg::colour_ant;
            end
            ant_pkg::drw_read_y: begin
                req_instr.addr.id    = id;
                req_instr.addr.field = ant_pkg::field_y;
            end
            default: begin
                req_instr.addr.id    = id;
                req_instr.addr.field = ant_pkg::field_x;
            end
        endcase
    end

endmodule

// File: verilog/ant_pkg.sv
package ant_pkg;

    // Word widths
    localparam int x_coord_width = 8;
    localparam int y_coord_width = 7;
    localparam int colour_width  = 3;
    localparam int fitness_width = 8;
    localparam int ant_id_width  = 4;
    localparam int result_width  = 16;

    typedef logic [x_coord_width-1:0] x_coord_t;
    typedef logic [y_coord_width-1:0] y_coord_t;
    typedef logic [colour_width-1:0]  colour_t;
    typedef logic [fitness_width-1:0] fitness_t;
    typedef logic [ant_id_width-1:0]  ant_id_t;
    typedef logic [result_width-1:0]  result_t;

    // Screen and sprite geometry
    localparam int screen_width  = 160;
    localparam int screen_height = 120;
    localparam int ant_width     = 4;
    localparam int ant_height    = 4;

    localparam colour_t colour_ant = 3'b100;

    // Clamp limits for the ant centre
    localparam x_coord_t x_min = x_coord_t'(ant_width / 2);
    localparam x_coord_t x_max = x_coord_t'(screen_width - ant_width / 2 - 1);
    localparam y_coord_t y_min = y_coord_t'(ant_height / 2);
    localparam y_coord_t y_max = y_coord_t'(screen_height - ant_height / 2 - 1);

    typedef enum logic [1:0] {
        op_memread  = 2'd0,
        op_memwrite = 2'd1,
        op_draw     = 2'd2
    } dp_op_t;

    typedef enum logic [1:0] {
        field_x       = 2'd0,
        field_y       = 2'd1,
        field_fitness = 2'd2
    } ant_field_t;

    typedef struct packed {
        ant_id_t    id;
        ant_field_t field;
    } ant_addr_t;

    typedef struct packed {
        dp_op_t    op;
        ant_addr_t addr;
        result_t   wdata;
        x_coord_t  px;
        y_coord_t  py;
        colour_t   colour;
    } dp_instr_t;

    typedef struct packed {
        logic left;
        logic right;
        logic up;
        logic down;
    } move_t;

    typedef enum logic [2:0] {
        upd_idle, upd_read_x, upd_read_y, upd_read_fit,
        upd_move, upd_write_x, upd_write_y, upd_write_fit
    } update_state_t;

    typedef enum logic [1:0] {drw_idle, drw_read_x, drw_read_y, drw_draw} draw_state_t;

    typedef enum logic [1:0] {tick_idle, tick_update, tick_draw} tick_state_t;

endpackage

// File: verilog/ant_tick.sv
`timescale 1ns/10ps

module ant_tick (
    input  logic               clock,
    input  logic               resetn,
    input  logic               start,
    input  ant_pkg::ant_id_t   id,
    input  ant_pkg::move_t     move,
    input  logic               finished_dp,
    input  ant_pkg::result_t   result_dp,
    output logic               finished,
    output logic               start_dp,
    output ant_pkg::dp_instr_t instr_dp
);

    ant_pkg::tick_state_t state;

    ant_pkg::ant_id_t id_q;
    ant_pkg::move_t   move_q;

    logic               run_update;
    logic               run_draw;
    logic               upd_req;
    logic               upd_complete;
    logic               drw_req;
    logic               drw_complete;
    logic               iss_req;
    logic               iss_done;
    ant_pkg::dp_instr_t upd_instr;
    ant_pkg::dp_instr_t drw_instr;
    ant_pkg::dp_instr_t iss_instr;
    ant_pkg::result_t   iss_result;

    always_ff @(posedge clock) begin
        if (!resetn) begin
            state      <= ant_pkg::tick_idle;
            finished   <= 1'b1;
            run_update <= 1'b0;
            run_draw   <= 1'b0;
        end else begin
            run_update <= 1'b0;
            run_draw   <= 1'b0;
            case (state)
                ant_pkg::tick_idle: begin
                    if (start && finished) begin
                        finished   <= 1'b0;
                        run_update <= 1'b1;
                        state      <= ant_pkg::tick_update;
                    end
                end
                ant_pkg::tick_update: begin
                    if (upd_complete) begin
                        run_draw <= 1'b1;
                        state    <= ant_pkg::tick_draw;
                    end
                end
                ant_pkg::tick_draw: begin
                    if (drw_complete) begin
                        finished <= 1'b1;
                        state    <= ant_pkg::tick_idle;
                    end
                end
                default: begin
                    state <= ant_pkg::tick_idle;
                end
            endcase
        end
    end

    // Step arguments, held for the whole tick
    always_ff @(posedge clock) begin
        if (state == ant_pkg::tick_idle && start && finished) begin
            id_q   <= id;
            move_q <= move;
        end
    end

    // Only the active phase reaches the issuer
    always_comb begin
        iss_req   = 1'b0;
        iss_instr = '0;
        case (state)
            ant_pkg::tick_update: begin
                iss_req   = upd_req;
                iss_instr = upd_instr;
            end
            ant_pkg::tick_draw: begin
                iss_req   = drw_req;
                iss_instr = drw_instr;
            end
            default: ;
        endcase
    end

    dp_issuer u_issuer (
        .clock       (clock),
        .resetn      (resetn),
        .req         (iss_req),
        .req_instr   (iss_instr),
        .finished_dp (finished_dp),
        .result_dp   (result_dp),
        .start_dp    (start_dp),
        .instr_dp    (instr_dp),
        .done        (iss_done),
        .result      (iss_result)
    );

    ant_update u_update (
        .clock     (clock),
        .resetn    (resetn),
        .run       (run_update),
        .id        (id_q),
        .move      (move_q),
        .done      (iss_done),
        .result    (iss_result),
        .req       (upd_req),
        .req_instr (upd_instr),
        .complete  (upd_complete)
    );

    ant_draw u_draw (
        .clock     (clock),
        .resetn    (resetn),
        .run       (run_draw),
        .id        (id_q),
        .done      (iss_done),
        .result    (iss_result),
        .req       (drw_req),
        .req_instr (drw_instr),
        .complete  (drw_complete)
    );

endmodule

// File: verilog/ant_update.sv
`timescale 1ns/10ps

module ant_update (
    input  logic               clock,
    input  logic               resetn,
    input  logic               run,
    input  ant_pkg::ant_id_t   id,
    input  ant_pkg::move_t     move,
    input  logic               done,
    input  ant_pkg::result_t   result,
    output logic               req,
    output ant_pkg::dp_instr_t req_instr,
    output logic               complete
);

    ant_pkg::update_state_t state;

    ant_pkg::x_coord_t x;
    ant_pkg::y_coord_t y;
    ant_pkg::fitness_t fitness;

    always_ff @(posedge clock) begin
        if (!resetn) begin
            state    <= ant_pkg::upd_idle;
            req      <= 1'b0;
            complete <= 1'b0;
        end else begin
            req      <= 1'b0;
            complete <= 1'b0;
            case (state)
                ant_pkg::upd_idle: begin
                    if (run) begin
                        req   <= 1'b1;
                        state <= ant_pkg::upd_read_x;
                    end
                end
                ant_pkg::upd_read_x: begin
                    if (done) begin
                        req   <= 1'b1;
                        state <= ant_pkg::upd_read_y;
                    end
                end
                ant_pkg::upd_read_y: begin
                    if (done) begin
                        req   <= 1'b1;
                        state <= ant_pkg::upd_read_fit;
                    end
                end
                ant_pkg::upd_read_fit: begin
                    if (done) begin
                        state <= ant_pkg::upd_move;
                    end
                end
                ant_pkg::upd_move: begin
                    req   <= 1'b1;
                    state <= ant_pkg::upd_write_x;
                end
                ant_pkg::upd_write_x: begin
                    if (done) begin
                        req   <= 1'b1;
                        state <= ant_pkg::upd_write_y;
                    end
                end
                ant_pkg::upd_write_y: begin
                    if (done) begin
                        req   <= 1'b1;
                        state <= ant_pkg::upd_write_fit;
                    end
                end
                ant_pkg::upd_write_fit: begin
                    if (done) begin
                        complete <= 1'b1;
                        state    <= ant_pkg::upd_idle;
                    end
                end
                default: begin
                    state <= ant_pkg::upd_idle;
                end
            endcase
        end
    end

    // Ant record and the clamped one-pixel step
    always_ff @(posedge clock) begin
        if (done && state == ant_pkg::upd_read_x) begin
            x <= ant_pkg::x_coord_t'(result);
        end
        if (done && state == ant_pkg::upd_read_y) begin
            y <= ant_pkg::y_coord_t'(result);
        end
        if (done && state == ant_pkg::upd_read_fit) begin
            fitness <= ant_pkg::fitness_t'(result);
        end
        if (state == ant_pkg::upd_move) begin
            if (move.left && x > ant_pkg::x_min) begin
                x <= x - 1'b1;
            end else if (move.right && x < ant_pkg::x_max) begin
                x <= x + 1'b1;
            end
            if (move.up && y > ant_pkg::y_min) begin
                y <= y - 1'b1;
            end else if (move.down && y < ant_pkg::y_max) begin
                y <= y + 1'b1;
            end
        end
    end

    // Command for the state just entered, held until the next request
    always_comb begin
        req_instr = '0;
        req_instr.addr.id = id;
        case (state)
            ant_pkg::upd_read_y:    req_instr.addr.field = ant_pkg::field_y;
            ant_pkg::upd_read_fit:  req_instr.addr.field = ant_pkg::field_fitness;
            ant_pkg::upd_write_x: begin
                req_instr.op    = ant_pkg::op_memwrite;
                req_instr.wdata = ant_pkg::result_t'(x);
            end
            ant_pkg::upd_write_y: begin
                req_instr.op         = ant_pkg::op_memwrite;
                req_instr.addr.field = ant_pkg::field_y;
                req_instr.wdata      = ant_pkg::result_t'(y);
            end
            ant_pkg::upd_write_fit: begin
                req_instr.op         = ant_pkg::op_memwrite;
                req_instr.addr.field = ant_pkg::field_fitness;
                req_instr.wdata      = ant_pkg::result_t'(fitness);
            end
            default: req_instr.addr.field = ant_pkg::field_x;
        endcase
    end

endmodule

// File: verilog/dp_issuer.sv
`timescale 1ns/10ps

module dp_issuer (
    input  logic               clock,
    input  logic               resetn,
    input  logic               req,
    input  ant_pkg::dp_instr_t req_instr,
    input  logic               finished_dp,
    input  ant_pkg::result_t   result_dp,
    output logic               start_dp,
    output ant_pkg::dp_instr_t instr_dp,
    output logic               done,
    output ant_pkg::result_t   result
);

    typedef enum logic [1:0] {iss_idle, iss_strobe_one, iss_strobe_two, iss_wait} issuer_state_t;

    issuer_state_t state;

    always_ff @(posedge clock) begin
        if (!resetn) begin
            state    <= iss_idle;
            start_dp <= 1'b0;
            instr_dp <= '0;
            done     <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                iss_idle: begin
                    if (req) begin
                        instr_dp <= req_instr;
                        start_dp <= 1'b1;
                        state    <= iss_strobe_one;
                    end
                end
                iss_strobe_one: begin
                    state <= iss_strobe_two;
                end
                // Strobe drops after its second cycle
                iss_strobe_two: begin
                    start_dp <= 1'b0;
                    state    <= iss_wait;
                end
                iss_wait: begin
                    if (finished_dp) begin
                        done  <= 1'b1;
                        state <= iss_idle;
                    end
                end
                default: begin
                    state <= iss_idle;
                end
            endcase
        end
    end

    // Result word is only meaningful alongside done
    always_ff @(posedge clock) begin
        if (state == iss_wait && finished_dp) begin
            result <= result_dp;
        end
    end

endmodule
